/* action_pkg.sv */
package action_pkg;

    localparam int phv_w      = 512;
    localparam int hdr_bytes  = 32;
    localparam int ram_depth  = 32;
    localparam int ram_addr_w = 5;
    localparam int ram_data_w = 32;
    localparam int max_op_w   = 64;

    typedef enum logic [3:0] {
        op_add      = 4'd1,
        op_sub      = 4'd2,
        op_addi     = 4'd3,
        op_subi     = 4'd4,
        op_load     = 4'd5,
        op_store    = 4'd6,
        op_redirect = 4'd8,
        op_discard  = 4'd9
    } opcode_e;

    // code 3 falls back to the 2-byte table
    typedef enum logic [1:0] {
        w2b = 2'd0,
        w4b = 2'd1,
        w8b = 2'd2
    } width_e;

    typedef struct packed {
        width_e     width;
        logic [2:0] idx;
    } field_sel_t;

    typedef struct packed {
        opcode_e     opcode;
        field_sel_t  sel_a;
        logic [15:0] arg;
    } action_t;

    typedef struct packed {
        logic [hdr_bytes-1:0][7:0]                 hdr;
        logic [7:0][7:0]                           off_2b;
        logic [7:0][7:0]                           off_4b;
        logic [7:0][7:0]                           off_8b;
        logic [7:0]                                out_port;
        logic [phv_w-hdr_bytes*8-3*64-8-1-1:0]     rsvd;
        logic                                      discard;
    } phv_t;

    typedef struct packed {
        logic                  en;
        logic [ram_addr_w-1:0] addr;
        logic [ram_data_w-1:0] data;
    } ram_wr_t;

    function automatic logic [3:0] width_bytes(input width_e w);
        case (w)
            w4b:     return 4'd4;
            w8b:     return 4'd8;
            default: return 4'd2;
        endcase
    endfunction

    function automatic logic [7:0] field_offset(input phv_t p, input field_sel_t s);
        case (s.width)
            w4b:     return p.off_4b[s.idx];
            w8b:     return p.off_8b[s.idx];
            default: return p.off_2b[s.idx];
        endcase
    endfunction

    // header byte 0 sits in hdr[hdr_bytes-1]
    function automatic logic [max_op_w-1:0] read_field(input phv_t p, input field_sel_t s);
        logic [7:0]          off;
        logic [4:0]          pos;
        logic [3:0]          nb;
        logic [max_op_w-1:0] val;
        off = field_offset(p, s);
        nb  = width_bytes(s.width);
        val = '0;
        for (int i = 0; i < 8; i++) begin
            if (4'(i) < nb) begin
                pos = off[4:0] + 5'(i);
                val = {val[max_op_w-9:0], p.hdr[5'(hdr_bytes-1) - pos]};
            end
        end
        return val;
    endfunction

    function automatic phv_t write_field(input phv_t p, input field_sel_t s,
                                         input logic [max_op_w-1:0] v);
        phv_t                r;
        logic [7:0]          off;
        logic [4:0]          pos;
        logic [3:0]          nb;
        logic [max_op_w-1:0] rest;
        r    = p;
        off  = field_offset(p, s);
        nb   = width_bytes(s.width);
        rest = v;
        // last byte of the field takes the lowest value byte
        for (int i = 7; i >= 0; i--) begin
            if (4'(i) < nb) begin
                pos = off[4:0] + 5'(i);
                r.hdr[5'(hdr_bytes-1) - pos] = rest[7:0];
                rest = rest >> 8;
            end
        end
        return r;
    endfunction

endpackage

/* kv_ram.sv */
`timescale 1ns/1ns

module kv_ram (
    input  logic                                  axis_clk,
    input  logic                                  aresetn,
    input  action_pkg::ram_wr_t                   wr,
    input  logic [action_pkg::ram_addr_w-1:0]     rd_addr,
    output logic [action_pkg::ram_data_w-1:0]     rd_data
);

    import action_pkg::*;

    logic [ram_data_w-1:0] mem [ram_depth];

    always_ff @(posedge axis_clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read word is ready one cycle after the address
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* alu_engine.sv */
`timescale 1ns/1ns

module alu_engine (
    input  logic                axis_clk,
    input  logic                aresetn,
    input  action_pkg::action_t action_in,
    input  logic                action_in_valid,
    input  action_pkg::phv_t    phv_in,
    output action_pkg::ram_wr_t ram_wr,
    output logic                done,
    output action_pkg::phv_t    phv
);

    import action_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_fetch,
        s_exec
    } state_e;

    state_e              state;
    action_t             act_q;
    phv_t                phv_q;
    logic [max_op_w-1:0] op_a;
    logic [max_op_w-1:0] op_b;
    logic                alu_op;
    logic                accept;
    field_sel_t          sel_fetch;
    field_sel_t          sel_b;
    logic [max_op_w-1:0] field_a;

    always_comb begin
        case (action_in.opcode)
            op_add, op_sub, op_addi, op_subi,
            op_store, op_redirect, op_discard: alu_op = 1'b1;
            default: alu_op = 1'b0;
        endcase
    end

    assign accept = action_in_valid && alu_op && (state == s_idle);

    // store always moves a 4-byte field
    always_comb begin
        sel_fetch = act_q.sel_a;
        if (act_q.opcode == op_store) begin
            sel_fetch.width = w4b;
        end
    end

    assign sel_b   = field_sel_t'(act_q.arg[15:11]);
    assign field_a = read_field(phv_q, sel_fetch);

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state  <= s_idle;
            done   <= 1'b0;
            ram_wr <= '0;
        end else begin
            done      <= 1'b0;
            ram_wr.en <= 1'b0;
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_fetch;
                    end
                end
                s_fetch: begin
                    state       <= s_exec;
                    ram_wr.en   <= (act_q.opcode == op_store);
                    ram_wr.addr <= act_q.arg[ram_addr_w-1:0];
                    ram_wr.data <= field_a[ram_data_w-1:0];
                end
                s_exec: begin
                    state <= s_idle;
                    done  <= 1'b1;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        case (state)
            s_idle: begin
                if (accept) begin
                    act_q <= action_in;
                    phv_q <= phv_in;
                end
            end
            s_fetch: begin
                op_a <= field_a;
                if (act_q.opcode inside {op_add, op_sub}) begin
                    op_b <= read_field(phv_q, sel_b);
                end else begin
                    op_b <= max_op_w'(act_q.arg);
                end
            end
            s_exec: begin
                // write_field keeps only the field's low bytes
                case (act_q.opcode)
                    op_add, op_addi: phv_q <= write_field(phv_q, act_q.sel_a, op_a + op_b);
                    op_sub, op_subi: phv_q <= write_field(phv_q, act_q.sel_a, op_a - op_b);
                    op_redirect:     phv_q.out_port <= act_q.arg[7:0];
                    op_discard:      phv_q.discard <= act_q.arg[0];
                    default:         phv_q <= phv_q;
                endcase
            end
            default: ;
        endcase
    end

    assign phv = phv_q;

endmodule

/* load_engine.sv */
`timescale 1ns/1ns

module load_engine (
    input  logic                              axis_clk,
    input  logic                              aresetn,
    input  action_pkg::action_t               action_in,
    input  logic                              action_in_valid,
    input  action_pkg::phv_t                  phv_in,
    input  logic [action_pkg::ram_data_w-1:0] rd_data,
    output logic [action_pkg::ram_addr_w-1:0] rd_addr,
    output logic                              done,
    output action_pkg::phv_t                  phv
);

    import action_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_wait,
        s_write
    } state_e;

    state_e     state;
    action_t    act_q;
    phv_t       phv_q;
    logic       accept;
    field_sel_t sel_dst;

    assign accept  = action_in_valid && (action_in.opcode == op_load) && (state == s_idle);
    assign rd_addr = act_q.arg[ram_addr_w-1:0];

    // loaded word always lands in a 4-byte field
    assign sel_dst = '{width: w4b, idx: act_q.sel_a.idx};

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= s_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_wait;
                    end
                end
                s_wait:  state <= s_write;
                s_write: begin
                    state <= s_idle;
                    done  <= 1'b1;
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            act_q <= action_in;
            phv_q <= phv_in;
        end else if (state == s_write) begin
            phv_q <= write_field(phv_q, sel_dst, max_op_w'(rd_data));
        end
    end

    assign phv = phv_q;

endmodule

/* phv_out_merge.sv */
`timescale 1ns/1ns

module phv_out_merge (
    input  logic             axis_clk,
    input  logic             aresetn,
    input  logic             alu_done,
    input  action_pkg::phv_t alu_phv,
    input  logic             load_done,
    input  action_pkg::phv_t load_phv,
    output action_pkg::phv_t phv_out,
    output logic             phv_out_valid
);

    // engines never finish together, both high counts as nothing
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            phv_out       <= '0;
            phv_out_valid <= 1'b0;
        end else begin
            case ({alu_done, load_done})
                2'b10: begin
                    phv_out       <= alu_phv;
                    phv_out_valid <= 1'b1;
                end
                2'b01: begin
                    phv_out       <= load_phv;
                    phv_out_valid <= 1'b1;
                end
                default: begin
                    phv_out       <= '0;
                    phv_out_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* action_engine.sv */
`timescale 1ns/1ns

module action_engine (
    input  logic                axis_clk,
    input  logic                aresetn,
    input  action_pkg::action_t action_in,
    input  logic                action_in_valid,
    input  action_pkg::phv_t    phv_in,
    output action_pkg::phv_t    phv_out,
    output logic                phv_out_valid
);

    import action_pkg::*;

    ram_wr_t               ram_wr;
    logic [ram_addr_w-1:0] rd_addr;
    logic [ram_data_w-1:0] rd_data;
    logic                  alu_done;
    logic                  load_done;
    phv_t                  alu_phv;
    phv_t                  load_phv;

    alu_engine u_alu (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .action_in       (action_in),
        .action_in_valid (action_in_valid),
        .phv_in          (phv_in),
        .ram_wr          (ram_wr),
        .done            (alu_done),
        .phv             (alu_phv)
    );

    load_engine u_load (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .action_in       (action_in),
        .action_in_valid (action_in_valid),
        .phv_in          (phv_in),
        .rd_data         (rd_data),
        .rd_addr         (rd_addr),
        .done            (load_done),
        .phv             (load_phv)
    );

    kv_ram u_ram (
        .axis_clk (axis_clk),
        .aresetn  (aresetn),
        .wr       (ram_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    phv_out_merge u_merge (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .alu_done      (alu_done),
        .alu_phv       (alu_phv),
        .load_done     (load_done),
        .load_phv      (load_phv),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid)
    );

endmodule

/* action_engine_properties.sv */
`timescale 1ns/1ns

module action_engine_properties (
    input logic axis_clk,
    input logic aresetn,
    input logic alu_done,
    input logic load_done,
    input logic ram_wr_en,
    input logic phv_out_valid
);

    done_exclusive: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        !(alu_done && load_done)
    ) else $error("ALU and load engine raised done in the same cycle");

    valid_after_done: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        (alu_done || load_done) |=> phv_out_valid
    ) else $error("phv_out_valid did not follow a done pulse");

    // no output without a done one cycle before
    valid_needs_done: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        phv_out_valid |-> $past(alu_done || load_done)
    ) else $error("phv_out_valid raised without a preceding done pulse");

    ram_write_pulse: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        ram_wr_en |=> !ram_wr_en
    ) else $error("RAM write enable held longer than one cycle");

endmodule

bind action_engine action_engine_properties u_properties (
    .axis_clk      (axis_clk),
    .aresetn       (aresetn),
    .alu_done      (alu_done),
    .load_done     (load_done),
    .ram_wr_en     (ram_wr.en),
    .phv_out_valid (phv_out_valid)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic axis_clk,
    output logic aresetn
);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    // released just after the second rising edge
    initial begin
        aresetn = 1'b0;
        repeat (2) @(posedge axis_clk);
        #1;
        aresetn = 1'b1;
    end

endmodule

/* action_engine_tb.sv */
`timescale 1ns/1ns

module action_engine_tb;

    import action_pkg::*;

    // the directed tests take roughly 1000 cycles
    localparam int timeout_cycles = 2000;

    logic    axis_clk;
    logic    aresetn;
    action_t action_in;
    logic    action_in_valid;
    phv_t    phv_in;
    phv_t    phv_out;
    logic    phv_out_valid;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] model_mem [32];

    tb_clock_gen u_clock_gen (
        .axis_clk (axis_clk),
        .aresetn  (aresetn)
    );

    action_engine u_action_engine (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .action_in       (action_in),
        .action_in_valid (action_in_valid),
        .phv_in          (phv_in),
        .phv_out         (phv_out),
        .phv_out_valid   (phv_out_valid)
    );

    function automatic void locate_field(input phv_t p, input field_sel_t s,
                                         output int off, output int nb);
        case (s.width)
            w4b: begin
                off = int'(p.off_4b[s.idx]);
                nb  = 4;
            end
            w8b: begin
                off = int'(p.off_8b[s.idx]);
                nb  = 8;
            end
            default: begin
                off = int'(p.off_2b[s.idx]);
                nb  = 2;
            end
        endcase
    endfunction

    // header byte 0 is the top byte of hdr, fields are big endian
    function automatic logic [63:0] get_bytes(input phv_t p, input field_sel_t s);
        logic [255:0] h;
        logic [63:0]  v;
        logic [7:0]   top;
        int           off;
        int           nb;
        h = p.hdr;
        v = '0;
        locate_field(p, s, off, nb);
        for (int i = 0; i < nb; i++) begin
            top = 8'(255 - 8 * (off + i));
            v   = {v[55:0], h[top -: 8]};
        end
        return v;
    endfunction

    function automatic phv_t put_bytes(input phv_t p, input field_sel_t s,
                                       input logic [63:0] v);
        phv_t         r;
        logic [255:0] h;
        logic [7:0]   top;
        logic [5:0]   lo;
        int           off;
        int           nb;
        r = p;
        h = p.hdr;
        locate_field(p, s, off, nb);
        for (int i = 0; i < nb; i++) begin
            top         = 8'(255 - 8 * (off + i));
            lo          = 6'(8 * (nb - 1 - i));
            h[top -: 8] = v[lo +: 8];
        end
        r.hdr = h;
        return r;
    endfunction

    function automatic action_t make_action(input logic [3:0] op, input logic [1:0] w,
                                            input logic [2:0] idx, input logic [15:0] arg);
        action_t a;
        a.opcode      = opcode_e'(op);
        a.sel_a.width = width_e'(w);
        a.sel_a.idx   = idx;
        a.arg         = arg;
        return a;
    endfunction

    // offsets kept low enough that every field fits in the header
    function automatic phv_t random_phv();
        phv_t p;
        for (int i = 0; i < 32; i++) begin
            p.hdr[5'(i)] = 8'($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            p.off_2b[3'(i)] = 8'($urandom_range(30, 0));
            p.off_4b[3'(i)] = 8'($urandom_range(28, 0));
            p.off_8b[3'(i)] = 8'($urandom_range(24, 0));
        end
        p.out_port = 8'($urandom);
        p.rsvd     = 55'({$urandom, $urandom});
        p.discard  = 1'($urandom);
        return p;
    endfunction

    task automatic model_apply(input action_t a, input phv_t p,
                               output phv_t e, output bit has_out);
        field_sel_t  sel_b;
        field_sel_t  sel_w;
        logic [63:0] va;
        logic [63:0] vb;
        e       = p;
        has_out = 1'b1;
        sel_b   = field_sel_t'(a.arg[15:11]);
        // store and load always move a 4-byte field
        sel_w       = a.sel_a;
        sel_w.width = w4b;
        va = get_bytes(p, a.sel_a);
        vb = get_bytes(p, sel_b);
        case (a.opcode)
            op_add:      e = put_bytes(p, a.sel_a, va + vb);
            op_sub:      e = put_bytes(p, a.sel_a, va - vb);
            op_addi:     e = put_bytes(p, a.sel_a, va + 64'(a.arg));
            op_subi:     e = put_bytes(p, a.sel_a, va - 64'(a.arg));
            op_store: begin
                vb = get_bytes(p, sel_w);
                model_mem[a.arg[4:0]] = vb[31:0];
            end
            op_load:     e = put_bytes(p, sel_w, 64'(model_mem[a.arg[4:0]]));
            op_redirect: e.out_port = a.arg[7:0];
            op_discard:  e.discard = a.arg[0];
            default:     has_out = 1'b0;
        endcase
    endtask

    task automatic assert_valid(input logic exp);
        checks++;
        assert (phv_out_valid === exp) else begin
            errors++;
            $display("Error at %0t ns: phv_out_valid expected %b, got %b",
                     $time, exp, phv_out_valid);
        end
    endtask

    task automatic compare_phv(input phv_t exp);
        checks++;
        assert (phv_out === exp) else begin
            errors++;
            $display("Error at %0t ns: phv_out expected %h, got %h", $time, exp, phv_out);
        end
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(posedge axis_clk);
            #1;
            assert_valid(1'b0);
        end
    endtask

    task automatic send_action(input action_t a, input phv_t p);
        @(posedge axis_clk);
        #1;
        action_in       = a;
        phv_in          = p;
        action_in_valid = 1'b1;
        @(posedge axis_clk);
        #1;
        action_in_valid = 1'b0;
    endtask

    // result comes out on the third edge after capture
    task automatic apply_and_check(input action_t a, input phv_t p);
        phv_t exp;
        bit   has_out;
        model_apply(a, p, exp, has_out);
        send_action(a, p);
        if (has_out) begin
            quiet_cycles(2);
            @(posedge axis_clk);
            #1;
            assert_valid(1'b1);
            compare_phv(exp);
        end else begin
            quiet_cycles(4);
        end
    endtask

    task automatic reset_and_reserved();
        phv_t zero;
        zero = '0;
        assert_valid(1'b0);
        compare_phv(zero);
        quiet_cycles(5);
        apply_and_check(make_action(4'd7, 2'd0, 3'd0, 16'($urandom)), random_phv());
        apply_and_check(make_action(4'd0, 2'd1, 3'd2, 16'($urandom)), random_phv());
        apply_and_check(make_action(4'd15, 2'd2, 3'd5, 16'($urandom)), random_phv());
    endtask

    // operand A at byte 0, operand B at byte 8
    task automatic wrap_case(input logic [3:0] op, input logic [1:0] w,
                             input logic [63:0] va, input logic [63:0] vb);
        action_t a;
        phv_t    p;
        a = make_action(op, w, 3'd0, {w, 3'd1, 11'd0});
        p = random_phv();
        p.off_2b[0] = 8'd0;
        p.off_4b[0] = 8'd0;
        p.off_8b[0] = 8'd0;
        p.off_2b[1] = 8'd8;
        p.off_4b[1] = 8'd8;
        p.off_8b[1] = 8'd8;
        p = put_bytes(p, a.sel_a, va);
        p = put_bytes(p, field_sel_t'(a.arg[15:11]), vb);
        apply_and_check(a, p);
    endtask

    task automatic add_sub_fields();
        wrap_case(op_add, 2'd0, 64'hffff, 64'd3);
        wrap_case(op_add, 2'd2, '1, 64'd2);
        wrap_case(op_sub, 2'd1, 64'd0, 64'd1);
        for (int w = 0; w < 3; w++) begin
            for (int n = 0; n < 40; n++) begin
                apply_and_check(make_action(n[0] ? op_sub : op_add, 2'(w), 3'($urandom),
                                            16'($urandom)), random_phv());
            end
        end
    endtask

    task automatic immediate_ops();
        for (int w = 0; w < 3; w++) begin
            for (int n = 0; n < 16; n++) begin
                apply_and_check(make_action(n[0] ? op_subi : op_addi, 2'(w), 3'($urandom),
                                            16'($urandom)), random_phv());
            end
        end
    endtask

    task automatic redirect_and_discard();
        phv_t p;
        apply_and_check(make_action(op_redirect, 2'd0, 3'd0, 16'($urandom)), random_phv());
        apply_and_check(make_action(op_redirect, 2'd1, 3'd3, 16'($urandom)), random_phv());
        p         = random_phv();
        p.discard = 1'b0;
        apply_and_check(make_action(op_discard, 2'd0, 3'd0, 16'h0001), p);
        p.discard = 1'b1;
        apply_and_check(make_action(op_discard, 2'd2, 3'd7, 16'hfffe), p);
    endtask

    task automatic store_then_load();
        logic [4:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = 5'(i * 4 + 3);
            apply_and_check(make_action(op_store, 2'($urandom), 3'($urandom),
                                        {11'($urandom), addr}), random_phv());
        end
        for (int i = 0; i < 8; i++) begin
            addr = 5'(i * 4 + 3);
            apply_and_check(make_action(op_load, 2'($urandom), 3'($urandom),
                                        {11'($urandom), addr}), random_phv());
        end
    endtask

    // a load one cycle behind an ALU action still runs
    // a second ALU action one cycle behind the first is dropped
    task automatic overlap_and_drop();
        action_t a1;
        action_t a2;
        phv_t    p1;
        phv_t    p2;
        phv_t    e1;
        phv_t    e2;
        bit      has_out;
        for (int drop = 0; drop < 2; drop++) begin
            p1 = random_phv();
            p2 = random_phv();
            a1 = make_action(op_add, 2'($urandom_range(2, 0)), 3'($urandom), 16'($urandom));
            if (drop == 0) begin
                a2 = make_action(op_load, 2'd1, 3'($urandom), 16'd7);
            end else begin
                a2 = make_action(op_addi, 2'd0, 3'($urandom), 16'($urandom));
            end
            model_apply(a1, p1, e1, has_out);
            if (drop == 0) begin
                model_apply(a2, p2, e2, has_out);
            end
            @(posedge axis_clk);
            #1;
            action_in       = a1;
            phv_in          = p1;
            action_in_valid = 1'b1;
            @(posedge axis_clk);
            #1;
            action_in = a2;
            phv_in    = p2;
            @(posedge axis_clk);
            #1;
            action_in_valid = 1'b0;
            quiet_cycles(1);
            @(posedge axis_clk);
            #1;
            assert_valid(1'b1);
            compare_phv(e1);
            @(posedge axis_clk);
            #1;
            assert_valid(1'(drop == 0));
            if (drop == 0) begin
                compare_phv(e2);
            end
            quiet_cycles(3);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge axis_clk);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(9681));
        action_in       = '0;
        action_in_valid = 1'b0;
        phv_in          = '0;
        errors          = 0;
        checks          = 0;
        wait (aresetn === 1'b1);
        reset_and_reserved();
        add_sub_fields();
        immediate_ops();
        redirect_and_discard();
        store_then_load();
        overlap_and_drop();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* action_engine.f */
action_pkg.sv
kv_ram.sv
alu_engine.sv
load_engine.sv
phv_out_merge.sv
action_engine.sv
action_engine_properties.sv
tb_clock_gen.sv
action_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the action engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module action_engine_tb -f action_engine.f -o action_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/action_engine_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
